//--- mips_single_cycle.f
mips_pkg.sv
program_counter.sv
instruction_memory.sv
control_unit.sv
register_file.sv
alu.sv
data_memory.sv
mips_single_cycle.sv
tb_clock.sv
mips_checker.sv
mips_tb.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = mips_tb
FILELIST   = mips_single_cycle.f
SIM        = obj_dir/V$(TOP)
PASS_MSG   = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status comes from the search for the pass line
run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- mips_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_tb import mips_pkg::*; ();

    localparam int DRIVE_DELAY  = 10;
    localparam int SAMPLE_DELAY = 80;   // drive point to just before the next edge
    localparam int TEST_CYCLES  = 400;  // rough length of all tests together
    localparam int MAX_CYCLES   = 5 * TEST_CYCLES;
    localparam logic [31:0] LFSR_SEED = 32'h248b_81e9;
    localparam wb_t     NO_WB = '0;
    localparam mem_wr_t NO_MW = '0;

    logic        clk;
    logic        arst_n;
    logic        run;
    imem_load_t  imem_load;
    logic [31:0] pc;
    wb_t         wb;
    mem_wr_t     mem_wr;
    logic        illegal;

    logic [31:0] prog [$];  // program words, loaded from address 0
    logic [31:0] lfsr_state;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;

    tb_clock clock_i (.clk);

    mips_single_cycle mips_single_cycle_i (
        .clk, .arst_n, .run, .imem_load, .pc, .wb, .mem_wr, .illegal
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input funct_e fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [25:0] target);
        return {OP_J, target};
    endfunction

    // writes to $0 never show up as valid
    function automatic wb_t mk_wb(input logic [4:0] rd, input logic [31:0] data);
        return '{valid: (rd != 5'd0), rd: rd, data: data};
    endfunction

    function automatic mem_wr_t mk_mw(input logic [31:0] byte_addr, input logic [31:0] data);
        return '{valid: 1'b1, addr: byte_addr[MEM_AW+1:2], data: data};
    endfunction

    task automatic check_pc(input string test, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s pc expected %h actual %h", test, exp, act);
        end
    endtask

    task automatic check_wb(input string test, input wb_t exp, input wb_t act);
        checks++;
        if (act.valid !== exp.valid ||
            (exp.valid && (act.rd !== exp.rd || act.data !== exp.data))) begin
            errors++;
            $display("ERR %s wb expected v=%0b rd=%0d data=%h actual v=%0b rd=%0d data=%h",
                     test, exp.valid, exp.rd, exp.data, act.valid, act.rd, act.data);
        end
    endtask

    task automatic check_mem_wr(input string test, input mem_wr_t exp, input mem_wr_t act);
        checks++;
        if (act.valid !== exp.valid ||
            (exp.valid && (act.addr !== exp.addr || act.data !== exp.data))) begin
            errors++;
            $display("ERR %s mem_wr expected v=%0b addr=%0d data=%h actual v=%0b addr=%0d data=%h",
                     test, exp.valid, exp.addr, exp.data, act.valid, act.addr, act.data);
        end
    endtask

    task automatic check_illegal(input string test, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s illegal expected %0b actual %0b", test, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic do_reset();
        arst_n = 1'b0;
        repeat (5) next_cycle();
        arst_n = 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            imem_load.we   = 1'b1;
            imem_load.addr = MEM_AW'(i);
            imem_load.data = prog[i];
            next_cycle();
        end
        imem_load = '0;
        prog.delete();
    endtask

    // pc back to 0, program in, core released
    task automatic begin_run();
        do_reset();
        load_program();
        run = 1'b1;
    endtask

    // one instruction, sampled just before it retires
    task automatic run_one(input string test, input logic [31:0] exp_pc, input wb_t exp_wb,
                           input mem_wr_t exp_mw, input logic exp_ill);
        #(SAMPLE_DELAY);
        check_pc(test, exp_pc, pc);
        check_wb(test, exp_wb, wb);
        check_mem_wr(test, exp_mw, mem_wr);
        check_illegal(test, exp_ill, illegal);
        next_cycle();
    endtask

    task automatic test_reset();
        logic [31:0] halted_words [3];
        halted_words[0] = enc_i(OP_ADDI, 5'd0, 5'd1, 16'd1);  // would write back
        halted_words[1] = enc_i(OP_SW, 5'd0, 5'd0, 16'd0);    // would store
        halted_words[2] = 32'hfc00_0000;                      // would pulse illegal
        run_one("reset", 32'd0, NO_WB, NO_MW, 1'b0);
        for (int i = 0; i < 3; i++) begin
            prog.push_back(halted_words[i]);
            load_program();
            repeat (2) run_one("reset", 32'd0, NO_WB, NO_MW, 1'b0);  // halted, nothing moves
        end
    endtask

    task automatic test_alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        a = 32'd25;
        b = 32'hffff_fff9;  // -7
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd1, a[15:0]));
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd2, b[15:0]));
        prog.push_back(enc_r(FN_ADD, 5'd1, 5'd2, 5'd3));
        prog.push_back(enc_r(FN_SUB, 5'd1, 5'd2, 5'd4));
        prog.push_back(enc_r(FN_AND, 5'd1, 5'd2, 5'd5));
        prog.push_back(enc_r(FN_OR, 5'd1, 5'd2, 5'd6));
        prog.push_back(enc_r(FN_SLT, 5'd2, 5'd1, 5'd7));
        prog.push_back(enc_r(FN_SLT, 5'd1, 5'd2, 5'd8));
        begin_run();
        run_one("alu_ops", 32'd0, mk_wb(5'd1, a), NO_MW, 1'b0);
        run_one("alu_ops", 32'd4, mk_wb(5'd2, b), NO_MW, 1'b0);
        run_one("alu_ops", 32'd8, mk_wb(5'd3, a + b), NO_MW, 1'b0);
        run_one("alu_ops", 32'd12, mk_wb(5'd4, a - b), NO_MW, 1'b0);
        run_one("alu_ops", 32'd16, mk_wb(5'd5, a & b), NO_MW, 1'b0);
        run_one("alu_ops", 32'd20, mk_wb(5'd6, a | b), NO_MW, 1'b0);
        run_one("alu_ops", 32'd24, mk_wb(5'd7, {31'd0, $signed(b) < $signed(a)}), NO_MW, 1'b0);
        run_one("alu_ops", 32'd28, mk_wb(5'd8, {31'd0, $signed(a) < $signed(b)}), NO_MW, 1'b0);
        run = 1'b0;
    endtask

    task automatic test_load_store();
        logic [31:0] base;
        logic [31:0] val;
        logic [31:0] off_a;
        logic [31:0] off_b;
        base  = 32'd12;
        val   = 32'h0000_1234;
        off_a = 32'd8;
        off_b = 32'hffff_fffc;  // negative offset
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd1, base[15:0]));
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd2, val[15:0]));
        prog.push_back(enc_i(OP_SW, 5'd1, 5'd2, off_a[15:0]));
        prog.push_back(enc_i(OP_LW, 5'd1, 5'd3, off_a[15:0]));
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd4, 16'hffff));
        prog.push_back(enc_i(OP_SW, 5'd1, 5'd4, off_b[15:0]));
        prog.push_back(enc_i(OP_LW, 5'd1, 5'd5, off_b[15:0]));
        begin_run();
        run_one("load_store", 32'd0, mk_wb(5'd1, base), NO_MW, 1'b0);
        run_one("load_store", 32'd4, mk_wb(5'd2, val), NO_MW, 1'b0);
        run_one("load_store", 32'd8, NO_WB, mk_mw(base + off_a, val), 1'b0);
        run_one("load_store", 32'd12, mk_wb(5'd3, val), NO_MW, 1'b0);
        run_one("load_store", 32'd16, mk_wb(5'd4, 32'hffff_ffff), NO_MW, 1'b0);
        run_one("load_store", 32'd20, NO_WB, mk_mw(base + off_b, 32'hffff_ffff), 1'b0);
        run_one("load_store", 32'd24, mk_wb(5'd5, 32'hffff_ffff), NO_MW, 1'b0);
        run = 1'b0;
    endtask

    task automatic test_branch_jump();
        logic [31:0] pc_exp;
        logic [15:0] off;
        logic [25:0] target;
        off    = 16'd2;
        target = 26'd10;  // word 10
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd1, 16'd5));
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd2, 16'd5));
        prog.push_back(enc_i(OP_BEQ, 5'd1, 5'd2, off));
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd9, 16'd99));  // skipped
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd9, 16'd99));
        prog.push_back(enc_i(OP_BEQ, 5'd1, 5'd0, 16'd3));     // 5 != 0, falls through
        prog.push_back(enc_j(target));
        while (prog.size() < 10) begin
            prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd9, 16'd98));
        end
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd3, 16'd7));
        begin_run();
        run_one("branch_jump", 32'd0, mk_wb(5'd1, 32'd5), NO_MW, 1'b0);
        run_one("branch_jump", 32'd4, mk_wb(5'd2, 32'd5), NO_MW, 1'b0);
        run_one("branch_jump", 32'd8, NO_WB, NO_MW, 1'b0);
        pc_exp = 32'd8 + 32'd4 + {{14{off[15]}}, off, 2'b00};
        run_one("branch_jump", pc_exp, NO_WB, NO_MW, 1'b0);
        pc_exp = pc_exp + 32'd4;
        run_one("branch_jump", pc_exp, NO_WB, NO_MW, 1'b0);
        pc_exp = pc_exp + 32'd4;
        pc_exp = {pc_exp[31:28], target, 2'b00};
        run_one("branch_jump", pc_exp, mk_wb(5'd3, 32'd7), NO_MW, 1'b0);
        run = 1'b0;
    endtask

    task automatic test_illegal_and_zero();
        prog.push_back(32'hfc00_0000);                             // opcode 0x3f
        prog.push_back({OP_RTYPE, 5'd1, 5'd2, 5'd3, 5'd0, 6'h3f}); // unknown funct
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd0, 16'd55));
        prog.push_back(enc_r(FN_ADD, 5'd0, 5'd0, 5'd5));
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd6, 16'd3));
        begin_run();
        run_one("illegal_zero", 32'd0, NO_WB, NO_MW, 1'b1);
        run_one("illegal_zero", 32'd4, NO_WB, NO_MW, 1'b1);
        run_one("illegal_zero", 32'd8, NO_WB, NO_MW, 1'b0);
        run_one("illegal_zero", 32'd12, mk_wb(5'd5, 32'd0), NO_MW, 1'b0);
        run_one("illegal_zero", 32'd16, mk_wb(5'd6, 32'd3), NO_MW, 1'b0);
        run = 1'b0;
    endtask

    task automatic test_random_add();
        logic [31:0] shadow [32];
        logic        known [32];
        wb_t         exp_q [$];
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] imm_ext;
        logic [31:0] sum;
        logic [31:0] pc_exp;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
            known[i]  = (i == 0);
        end
        for (int n = 0; n < 20; n++) begin
            ra      = 5'(rand_bits(5));
            rb      = 5'(rand_bits(5));
            rd      = 5'(rand_bits(5));
            imm     = 16'(rand_bits(16));
            imm_ext = {{16{imm[15]}}, imm};
            prog.push_back(enc_i(OP_ADDI, 5'd0, ra, imm));
            exp_q.push_back(mk_wb(ra, imm_ext));
            if (ra != 5'd0) begin
                shadow[ra] = imm_ext;
                known[ra]  = 1'b1;
            end
            if (!known[rb]) begin
                rb = 5'd0;  // never read an unwritten register
            end
            sum = shadow[ra] + shadow[rb];  // wraps at 32 bits
            prog.push_back(enc_r(FN_ADD, ra, rb, rd));
            exp_q.push_back(mk_wb(rd, sum));
            if (rd != 5'd0) begin
                shadow[rd] = sum;
                known[rd]  = 1'b1;
            end
        end
        begin_run();
        pc_exp = 32'd0;
        for (int n = 0; n < exp_q.size(); n++) begin
            run_one("random_add", pc_exp, exp_q[n], NO_MW, 1'b0);
            pc_exp = pc_exp + 32'd4;
        end
        run = 1'b0;
    endtask

    initial begin
        arst_n     = 1'b0;
        run        = 1'b0;
        imem_load  = '0;
        lfsr_state = LFSR_SEED;
        do_reset();
        test_reset();
        test_alu_ops();
        test_load_store();
        test_branch_jump();
        test_illegal_and_zero();
        test_random_add();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mips_checker import mips_pkg::*; (
    input logic            clk,
    input logic            arst_n,
    input logic            run,
    input logic [XLEN-1:0] pc,
    input wb_t             wb,
    input mem_wr_t         mem_wr
);

    // nothing retires while the core is halted
    a_halted_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !run |-> (!wb.valid && !mem_wr.valid))
        else $error("write-back or store reported while run is low");

    a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        wb.valid |-> (wb.rd != 5'd0))
        else $error("write-back to register 0 reported as valid");

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // halted core keeps its pc
    a_pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !run |=> $stable(pc))
        else $error("pc moved while run was low");

endmodule

bind mips_single_cycle mips_checker mips_checker_i (.clk, .arst_n, .run, .pc, .wb, .mem_wr);

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 50;  // 100 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- mips_single_cycle.sv
`timescale 1ns/1ns
`default_nettype none

module mips_single_cycle import mips_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            run,
    input  imem_load_t      imem_load,
    output logic [XLEN-1:0] pc,
    output wb_t             wb,
    output mem_wr_t         mem_wr,
    output logic            illegal
);

    imem_load_t      load_gated;
    logic [XLEN-1:0] instr;
    ctrl_t           ctrl;
    logic            illegal_dec;
    logic [XLEN-1:0] imm_ext;
    logic [4:0]      write_reg;
    logic [XLEN-1:0] rs_data, rt_data;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] result;
    logic            zero;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] write_data;
    logic            rf_we;
    logic            dm_we;

    // loading is only allowed while the core is halted
    always_comb begin
        load_gated    = imem_load;
        load_gated.we = imem_load.we & ~run;
    end

    program_counter program_counter_i (
        .clk, .arst_n, .run,
        .branch(ctrl.branch), .jump(ctrl.jump), .zero,
        .imm_ext, .jump_field(instr[25:0]), .pc
    );

    instruction_memory instruction_memory_i (.clk, .load(load_gated), .pc, .instr);

    control_unit control_unit_i (.instr, .ctrl, .illegal(illegal_dec));

    assign imm_ext   = {{16{instr[15]}}, instr[15:0]};
    assign write_reg = ctrl.reg_dst ? instr[15:11] : instr[20:16];  // rd or rt
    assign rf_we     = run & ctrl.reg_write;
    assign dm_we     = run & ctrl.mem_write;

    register_file register_file_i (
        .clk, .we(rf_we),
        .rs(instr[25:21]), .rt(instr[20:16]), .rd(write_reg),
        .wdata(write_data), .rs_data, .rt_data
    );

    assign alu_b = ctrl.alu_src ? imm_ext : rt_data;

    alu alu_i (.a(rs_data), .b(alu_b), .op(ctrl.alu_op), .result, .zero);

    data_memory data_memory_i (.clk, .we(dm_we), .addr(result), .wdata(rt_data), .rdata);

    assign write_data = ctrl.mem_to_reg ? rdata : result;

    // retire view, writes to $0 are not reported
    assign wb.valid     = rf_we & (write_reg != 5'd0);
    assign wb.rd        = write_reg;
    assign wb.data      = write_data;
    assign mem_wr.valid = dm_we;
    assign mem_wr.addr  = result[MEM_AW+1:2];
    assign mem_wr.data  = rt_data;
    assign illegal      = run & illegal_dec;

endmodule

`default_nettype wire

//--- data_memory.sv
`timescale 1ns/1ns
`default_nettype none

module data_memory import mips_pkg::*; (
    input  logic            clk,
    input  logic            we,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata
);

    logic [XLEN-1:0]   mem [DMEM_DEPTH];
    logic [MEM_AW-1:0] word_addr;

    assign word_addr = addr[MEM_AW+1:2];  // word access only, upper bits ignored

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_addr] <= wdata;
        end
    end

    assign rdata = mem[word_addr];  // lw result in the same cycle

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import mips_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            less;

    assign sum  = a + b;
    assign diff = a - b;
    assign less = $signed(a) < $signed(b);  // slt is signed

    always_comb begin
        case (op)
            ALU_ADD: result = sum;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, less};
            default: result = '0;
        endcase
    end

    // beq uses this after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file import mips_pkg::*; (
    input  logic            clk,
    input  logic            we,
    input  logic [4:0]      rs,
    input  logic [4:0]      rt,
    input  logic [4:0]      rd,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rs_data,
    output logic [XLEN-1:0] rt_data
);

    logic [XLEN-1:0] regs [32];

    // $0 is never written
    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // $0 masked on read, its storage stays undefined
    assign rs_data = (rs == 5'd0) ? '0 : regs[rs];
    assign rt_data = (rt == 5'd0) ? '0 : regs[rt];

endmodule

`default_nettype wire

//--- control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit import mips_pkg::*; (
    input  logic [XLEN-1:0] instr,
    output ctrl_t           ctrl,
    output logic            illegal
);

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);

    always_comb begin
        ctrl    = CTRL_NOP;
        illegal = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD: ctrl.alu_op = ALU_ADD;
                    FN_SUB: ctrl.alu_op = ALU_SUB;
                    FN_AND: ctrl.alu_op = ALU_AND;
                    FN_OR:  ctrl.alu_op = ALU_OR;
                    FN_SLT: ctrl.alu_op = ALU_SLT;
                    default: begin  // unknown funct retires as a no-op
                        ctrl    = CTRL_NOP;
                        illegal = 1'b1;
                    end
                endcase
            end
            OP_ADDI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;  // zero flag gives equality
            end
            OP_J: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- instruction_memory.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_memory import mips_pkg::*; (
    input  logic            clk,
    input  imem_load_t      load,
    input  logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] instr
);

    logic [XLEN-1:0]   mem [IMEM_DEPTH];
    logic [MEM_AW-1:0] fetch_addr;

    // program load port, top level only lets it through while halted
    always_ff @(posedge clk) begin
        if (load.we) begin
            mem[load.addr] <= load.data;
        end
    end

    assign fetch_addr = pc[MEM_AW+1:2];  // drop byte offset
    assign instr      = mem[fetch_addr];

endmodule

`default_nettype wire

//--- program_counter.sv
`timescale 1ns/1ns
`default_nettype none

module program_counter import mips_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            run,
    input  logic            branch,
    input  logic            jump,
    input  logic            zero,
    input  logic [XLEN-1:0] imm_ext,
    input  logic [25:0]     jump_field,
    output logic [XLEN-1:0] pc
);

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] pc_next;

    assign pc_plus4      = pc + XLEN'(4);
    assign branch_target = pc_plus4 + {imm_ext[XLEN-3:0], 2'b00};  // offset counts words
    assign jump_target   = {pc_plus4[XLEN-1:28], jump_field, 2'b00};

    always_comb begin
        if (jump) begin
            pc_next = jump_target;
        end else if (branch && zero) begin  // beq taken
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int XLEN       = 32;
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int MEM_AW     = 6;   // word address, byte bits 7:2

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type funct field, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    // classic ALU control encoding
    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } alu_op_e;

    typedef struct packed {
        logic    reg_dst;     // 1: rd, 0: rt
        logic    alu_src;     // 1: immediate operand
        logic    mem_to_reg;  // 1: write back load data
        logic    reg_write;
        logic    mem_write;
        logic    branch;
        logic    jump;
        alu_op_e alu_op;
    } ctrl_t;

    // everything off, used for illegal encodings
    localparam ctrl_t CTRL_NOP = '{
        reg_dst:    1'b0,
        alu_src:    1'b0,
        mem_to_reg: 1'b0,
        reg_write:  1'b0,
        mem_write:  1'b0,
        branch:     1'b0,
        jump:       1'b0,
        alu_op:     ALU_ADD
    };

    typedef struct packed {
        logic              we;
        logic [MEM_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } imem_load_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic              valid;
        logic [MEM_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } mem_wr_t;

endpackage

`default_nettype wire
